// ==== Bender.yml ====
package:
  name: rosc_core

sources:
  - rosc_pkg.sv
  - osc_sampler.sv
  - entropy_collector.sv
  - rosc_api.sv
  - rosc_core.sv
  - target: test
    files:
      - rosc_core_checker.sv
      - tb_rosc_core.sv

// ==== entropy_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

// Sample timer, collector FSM and entropy word assembly
module entropy_collector #(
  parameter rosc_pkg::cycle_ctr_t SAMPLE_RATE = rosc_pkg::DEFAULT_SAMPLE_RATE
) (
  input  logic                      clk,
  input  logic                      cycle_ctr_rst,
  input  rosc_pkg::osc_history_t    f_hist,
  input  rosc_pkg::osc_history_t    g_hist,
  input  logic                      entropy_read,
  output logic                      sample_strb,
  output rosc_pkg::entropy_status_t status
);

  import rosc_pkg::*;

  // --------------------------------------------------
  // State
  // --------------------------------------------------

  // Free-running timer between strobes
  cycle_ctr_t     cycle_ctr_reg;
  logic           cycle_ctr_done;

  // FSM
  collect_state_t state_reg;
  collect_state_t state_new;

  // Accepted bit count and word being built
  bit_ctr_t       bit_ctr_reg;
  entropy_word_t  entropy_reg;

  // Full word waiting for a read
  logic           valid_reg;

  // Evaluation terms
  logic           f_par;
  logic           g_par;
  logic           accept;
  logic           last_bit;

  // --------------------------------------------------
  // Timer and strobe
  // --------------------------------------------------

  assign cycle_ctr_done = (cycle_ctr_reg == SAMPLE_RATE);

  // Strobe only while sampling, one cycle wide
  assign sample_strb = cycle_ctr_done &&
                       ((state_reg == CTRL_SAMPLE1) || (state_reg == CTRL_SAMPLE2));

  // --------------------------------------------------
  // Acceptance rule
  // --------------------------------------------------

  // Parity over both samples of each bank
  assign f_par = ^f_hist.hist;
  assign g_par = ^g_hist.hist;

  // Banks must disagree
  // No accept while a word waits or is being read
  assign accept = (state_reg == CTRL_EVALUATE) && (f_par != g_par) &&
                  !valid_reg && !entropy_read;

  // This accept fills the word
  assign last_bit = (bit_ctr_reg == bit_ctr_t'(31));

  // Next state
  always_comb begin
    state_new = state_reg;
    case (state_reg)
      CTRL_SAMPLE1: begin
        if (sample_strb) begin
          state_new = CTRL_SAMPLE2;
        end
      end
      CTRL_SAMPLE2: begin
        if (sample_strb) begin
          state_new = CTRL_EVALUATE;
        end
      end
      // Single cycle, always back to sampling
      CTRL_EVALUATE: begin
        state_new = CTRL_SAMPLE1;
      end
      default: begin
        state_new = CTRL_SAMPLE1;
      end
    endcase
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (cycle_ctr_rst) begin
      cycle_ctr_reg <= '0;
      state_reg     <= CTRL_SAMPLE1;
      bit_ctr_reg   <= '0;
      entropy_reg   <= '0;
      valid_reg     <= 1'b0;
    end else begin
      // Timer wraps at the rate, keeps running while a word waits
      if (cycle_ctr_done) begin
        cycle_ctr_reg <= '0;
      end else begin
        cycle_ctr_reg <= cycle_ctr_reg + cycle_ctr_t'(1);
      end

      state_reg <= state_new;

      // Read wins, restarts collection
      if (entropy_read) begin
        bit_ctr_reg <= '0;
        valid_reg   <= 1'b0;
      end else if (accept) begin
        bit_ctr_reg <= bit_ctr_reg + bit_ctr_t'(1);
        if (last_bit) begin
          valid_reg <= 1'b1;
        end
      end

      // New bit enters at the LSB, first bit ends up MSB
      if (accept) begin
        entropy_reg <= {entropy_reg[30:0], g_par};
      end
    end
  end

  // To the register API
  assign status.word  = entropy_reg;
  assign status.valid = valid_reg;

endmodule

`default_nettype wire

// ==== osc_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

// One oscillator bank sampled into a two-bit parity history
module osc_sampler #(
  parameter int NUM_ROSC = rosc_pkg::DEFAULT_NUM_ROSC
) (
  input  logic                  clk,
  input  logic                  cycle_ctr_rst,
  input  logic [NUM_ROSC-1:0]   osc,
  input  logic                  sample_strb,
  output rosc_pkg::osc_history_t hist
);

  // --------------------------------------------------
  // Synchronizer
  // --------------------------------------------------

  // First stage may go metastable
  logic [NUM_ROSC-1:0] sync1_reg;
  // Second stage is the settled copy
  logic [NUM_ROSC-1:0] sync2_reg;

  // Bank parity of the settled lines
  logic parity;

  // History register
  rosc_pkg::osc_history_t hist_reg;

  // Each line gets its own two-flop chain
  always_ff @(posedge clk) begin
    if (cycle_ctr_rst) begin
      sync1_reg <= '0;
      sync2_reg <= '0;
    end else begin
      sync1_reg <= osc;
      sync2_reg <= sync1_reg;
    end
  end

  // --------------------------------------------------
  // Parity and history
  // --------------------------------------------------

  // XOR of all oscillators in the bank
  assign parity = ^sync2_reg;

  // Shift on the edge that closes the strobe cycle
  // Parity reflects inputs from three edges back
  always_ff @(posedge clk) begin
    if (cycle_ctr_rst) begin
      hist_reg.hist <= 2'b00;
    end else if (sample_strb) begin
      // Old newest becomes previous
      hist_reg.hist <= {hist_reg.hist[0], parity};
    end
  end

  // Registered history straight out
  assign hist = hist_reg;

endmodule

`default_nettype wire

// ==== rosc_api.sv ====
`timescale 1ns/1ps
`default_nettype none

// Register decode for the entropy source
module rosc_api (
  input  logic                      cs,
  input  logic                      we,
  input  rosc_pkg::bus_addr_t       address,
  input  rosc_pkg::bus_data_t       write_data,
  input  rosc_pkg::entropy_status_t status,
  output rosc_pkg::bus_data_t       read_data,
  output logic                      ready,
  output logic                      entropy_read
);

  import rosc_pkg::*;

  // --------------------------------------------------
  // Access decode
  // --------------------------------------------------

  // Read strobe for this register block
  logic rd_en;

  // Every access completes in its own cycle
  assign ready = cs;

  assign rd_en = cs && !we;

  // Entropy read tells the collector the word is taken
  assign entropy_read = rd_en && (address == ADDR_ENTROPY);

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------

  // Write data goes nowhere, no writable registers here
  // Writes still complete with ready
  always_comb begin
    read_data = '0;
    if (rd_en) begin
      case (address)
        // Ready flag only, rest reads zero
        ADDR_STATUS: begin
          read_data[STATUS_READY_BIT] = status.valid;
        end
        ADDR_ENTROPY: begin
          read_data = status.word;
        end
        // Unmapped reads return zero
        default: begin
          read_data = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rosc_core.f ====
rosc_pkg.sv
osc_sampler.sv
entropy_collector.sv
rosc_api.sv
rosc_core.sv
rosc_core_checker.sv
tb_rosc_core.sv

// ==== rosc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// Ring oscillator entropy source, register bus view
module rosc_core #(
  parameter int                   NUM_ROSC    = rosc_pkg::DEFAULT_NUM_ROSC,
  parameter rosc_pkg::cycle_ctr_t SAMPLE_RATE = rosc_pkg::DEFAULT_SAMPLE_RATE
) (
  input  logic                clk,
  input  logic                cycle_ctr_rst,
  // Raw oscillator banks from the LUT loops
  input  logic [NUM_ROSC-1:0] osc_f,
  input  logic [NUM_ROSC-1:0] osc_g,
  // Register bus
  input  logic                cs,
  input  logic                we,
  input  rosc_pkg::bus_addr_t address,
  input  rosc_pkg::bus_data_t write_data,
  output rosc_pkg::bus_data_t read_data,
  output logic                ready
);

  import rosc_pkg::*;

  // Strobe shared by both banks
  logic            sample_strb;
  // Parity histories
  osc_history_t    f_hist;
  osc_history_t    g_hist;
  // Word and ready flag toward the API
  entropy_status_t status;
  // Word consumed by a bus read
  logic            entropy_read;

  // --------------------------------------------------
  // Bank samplers
  // --------------------------------------------------

  osc_sampler #(.NUM_ROSC(NUM_ROSC)) f_sampler (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .osc           (osc_f),
    .sample_strb   (sample_strb),
    .hist          (f_hist)
  );

  osc_sampler #(.NUM_ROSC(NUM_ROSC)) g_sampler (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .osc           (osc_g),
    .sample_strb   (sample_strb),
    .hist          (g_hist)
  );

  // --------------------------------------------------
  // Collector and register API
  // --------------------------------------------------

  entropy_collector #(.SAMPLE_RATE(SAMPLE_RATE)) collector (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .f_hist        (f_hist),
    .g_hist        (g_hist),
    .entropy_read  (entropy_read),
    .sample_strb   (sample_strb),
    .status        (status)
  );

  rosc_api api (
    .cs           (cs),
    .we           (we),
    .address      (address),
    .write_data   (write_data),
    .status       (status),
    .read_data    (read_data),
    .ready        (ready),
    .entropy_read (entropy_read)
  );

endmodule

`default_nettype wire

// ==== rosc_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Bus and collector properties, bound into rosc_core
module rosc_core_checker (
  input logic                      clk,
  input logic                      cycle_ctr_rst,
  input logic                      cs,
  input logic                      we,
  input rosc_pkg::bus_addr_t       address,
  input logic                      ready,
  input logic                      sample_strb,
  input logic                      entropy_read,
  input rosc_pkg::entropy_status_t status
);

  import rosc_pkg::*;

  // --------------------------------------------------
  // Bus
  // --------------------------------------------------

  // Zero wait states, ready mirrors the select
  ready_follows_cs: assert property (@(posedge clk) disable iff (cycle_ctr_rst)
    ready == cs)
    else $error("ready differs from cs");

  // Consume pulse only from a real entropy read
  read_pulse_source: assert property (@(posedge clk) disable iff (cycle_ctr_rst)
    entropy_read |-> (cs && !we && (address == ADDR_ENTROPY)))
    else $error("entropy_read without a read of the entropy register");

  // --------------------------------------------------
  // Collector
  // --------------------------------------------------

  // Strobe is a single-cycle pulse
  strobe_single: assert property (@(posedge clk) disable iff (cycle_ctr_rst)
    sample_strb |=> !sample_strb)
    else $error("sample_strb high in two consecutive cycles");

  // Only a read drops the ready flag
  valid_held: assert property (@(posedge clk) disable iff (cycle_ctr_rst)
    $fell(status.valid) |-> $past(entropy_read))
    else $error("valid fell without an entropy read");

endmodule

bind rosc_core rosc_core_checker chk_i (
  .clk           (clk),
  .cycle_ctr_rst (cycle_ctr_rst),
  .cs            (cs),
  .we            (we),
  .address       (address),
  .ready         (ready),
  .sample_strb   (sample_strb),
  .entropy_read  (entropy_read),
  .status        (status)
);

`default_nettype wire

// ==== rosc_pkg.sv ====
`default_nettype none

package rosc_pkg;

  // --------------------------------------------------
  // Widths with a meaning
  // --------------------------------------------------

  // Register bus address and data
  typedef logic [7:0]  bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // Assembled entropy word, one accepted bit per position
  typedef logic [31:0] entropy_word_t;

  // Sample timer, counts clock cycles between strobes
  typedef logic [15:0] cycle_ctr_t;

  // Accepted bits so far, wraps after 32
  typedef logic [4:0]  bit_ctr_t;

  // --------------------------------------------------
  // Collector FSM
  // --------------------------------------------------

  // Two sample strobes, then one evaluate cycle
  typedef enum logic [1:0] {
    CTRL_SAMPLE1  = 2'd0,
    CTRL_SAMPLE2  = 2'd1,
    CTRL_EVALUATE = 2'd2
  } collect_state_t;

  // --------------------------------------------------
  // Shared bundles
  // --------------------------------------------------

  // Parity history of one bank
  // Bit 0 newest, bit 1 previous
  typedef struct packed {
    logic [1:0] hist;
  } osc_history_t;

  // Collector result as seen by the register API
  typedef struct packed {
    entropy_word_t word;
    logic          valid;
  } entropy_status_t;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------

  // Status register, ready flag in bit 0
  localparam bus_addr_t ADDR_STATUS      = 8'h09;
  localparam int        STATUS_READY_BIT = 0;

  // Entropy word, read clears ready
  localparam bus_addr_t ADDR_ENTROPY     = 8'h20;

  // Top level defaults
  // Total oscillator count is twice NUM_ROSC
  localparam int         DEFAULT_NUM_ROSC    = 16;
  localparam cycle_ctr_t DEFAULT_SAMPLE_RATE = 16'h1000;

endpackage

`default_nettype wire

// ==== tb_rosc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rosc_core;

  import rosc_pkg::*;

  localparam int         NUM_ROSC     = 4;
  localparam cycle_ctr_t SAMPLE_RATE  = 16'd8;
  localparam int         STROBE_LIMIT = 20;
  localparam int         READY_LIMIT  = 8;
  localparam int         ROW_LIMIT    = 400;
  localparam int         RAND_ROWS    = 64;

  // Bus operation per slot
  localparam int OP_NONE       = 0;
  localparam int OP_STATUS     = 1;
  localparam int OP_ENTROPY    = 2;
  localparam int OP_WR_STATUS  = 3;
  localparam int OP_WR_ENTROPY = 4;
  localparam int OP_UNUSED     = 5;

  // One stimulus row
  // Expectations sit on the second row of a pair
  typedef struct packed {
    logic [NUM_ROSC-1:0] f;
    logic [NUM_ROSC-1:0] g;
    logic                has_exp;
    logic                exp_acc;
    logic                exp_bit;
  } row_t;

  logic                clk;
  logic                cycle_ctr_rst;
  logic [NUM_ROSC-1:0] osc_f;
  logic [NUM_ROSC-1:0] osc_g;
  logic                cs;
  logic                we;
  bus_addr_t           address;
  bus_data_t           write_data;
  bus_data_t           read_data;
  logic                ready;

  row_t fixed_tab [0:15];
  row_t rand_tab  [0:RAND_ROWS-1];
  row_t idle_row;
  row_t pend_row;

  int   errors;
  int   checks;
  int   strobe_idx;
  int   n;
  bus_data_t rdata;

  // Raw random words for the random rows
  logic [31:0] rnd_f;
  logic [31:0] rnd_g;

  // Reference model state
  entropy_word_t m_word;
  int            m_count;
  logic          m_valid;
  logic          first_pf;
  logic          first_pg;

  rosc_core #(.NUM_ROSC(NUM_ROSC), .SAMPLE_RATE(SAMPLE_RATE)) uut (
    .clk           (clk),
    .cycle_ctr_rst (cycle_ctr_rst),
    .osc_f         (osc_f),
    .osc_g         (osc_g),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .read_data     (read_data),
    .ready         (ready)
  );

  always #50 clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  function automatic row_t make_row(input logic [NUM_ROSC-1:0] f,
                                    input logic [NUM_ROSC-1:0] g,
                                    input logic has, input logic acc, input logic b);
    row_t r;
    r.f       = f;
    r.g       = g;
    r.has_exp = has;
    r.exp_acc = acc;
    r.exp_bit = b;
    return r;
  endfunction

  task automatic end_run;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                             input string message);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR at %0t: %s, expected %h, got %h", $time, message, expected, actual);
    end
  endtask

  // Find the strobe cycle at the falling edge
  task automatic wait_strobe;
    int   t;
    logic seen;
    seen = 1'b0;
    for (t = 0; t < STROBE_LIMIT && !seen; t++) begin
      @(negedge clk);
      seen = uut.sample_strb;
    end
    if (!seen) begin
      $display("Timeout: no sample strobe within %0d cycles", STROBE_LIMIT);
      errors++;
      end_run();
    end else begin
      strobe_idx++;
    end
  endtask

  // Odd strobe closes a pair and evaluates it
  task automatic model_eval;
    logic pf;
    logic pg;
    logic acc;
    pf = ^pend_row.f;
    pg = ^pend_row.g;
    if (strobe_idx % 2 == 0) begin
      first_pf = pf;
      first_pg = pg;
    end else begin
      acc = ((first_pf ^ pf) != (first_pg ^ pg)) && !m_valid;
      if (pend_row.has_exp && !m_valid) begin
        check_value(pend_row.exp_acc, acc, "table accept decision");
        if (acc) begin
          check_value(pend_row.exp_bit, first_pg ^ pg, "table accepted bit");
        end
      end
      if (acc) begin
        m_word = {m_word[30:0], first_pg ^ pg};
        m_count++;
        if (m_count == 32) begin
          m_valid = 1'b1;
        end
      end
    end
  endtask

  // One strobe period with a bus access after the evaluate cycle
  // New row goes out last
  task automatic run_slot(input row_t row, input int op, output bus_data_t rd);
    bus_data_t exp;
    wait_strobe();
    model_eval();
    @(posedge clk);
    @(negedge clk);
    check_value(0, ready, "ready while idle");
    @(posedge clk);
    cs      <= (op != OP_NONE);
    we      <= (op == OP_WR_STATUS) || (op == OP_WR_ENTROPY);
    address <= (op == OP_STATUS || op == OP_WR_STATUS) ? ADDR_STATUS :
               (op == OP_UNUSED) ? 8'h44 : ADDR_ENTROPY;
    write_data <= 32'hffff_ffff;
    @(negedge clk);
    rd  = read_data;
    exp = '0;
    if (op == OP_STATUS) begin
      exp[STATUS_READY_BIT] = m_valid;
    end else if (op == OP_ENTROPY) begin
      exp = m_word;
    end
    if (op != OP_NONE) begin
      check_value(1, ready, "ready during access");
      check_value(exp, rd, $sformatf("read_data for op %0d", op));
    end
    if (op == OP_ENTROPY) begin
      m_valid = 1'b0;
      m_count = 0;
    end
    @(posedge clk);
    cs         <= 1'b0;
    we         <= 1'b0;
    address    <= '0;
    write_data <= '0;
    @(posedge clk);
    osc_f <= row.f;
    osc_g <= row.g;
    pend_row = row;
  endtask

  // Next row must land on the first strobe of a pair
  task automatic align_to_pair;
    bus_data_t rd;
    if (strobe_idx % 2 == 1) begin
      run_slot(idle_row, OP_NONE, rd);
    end
  endtask

  task automatic poll_ready;
    int        t;
    bus_data_t rd;
    rd = '0;
    for (t = 0; t < READY_LIMIT && !rd[STATUS_READY_BIT]; t++) begin
      run_slot(idle_row, OP_STATUS, rd);
    end
    if (!rd[STATUS_READY_BIT]) begin
      $display("Timeout: status never reported a ready word");
      errors++;
      end_run();
    end
  endtask

  // Feed table rows until the model holds a full word
  task automatic feed_rows(input int phase, input int first_n);
    int        k;
    int        op;
    row_t      row;
    bus_data_t rd;
    k = first_n;
    while (!m_valid && k < ROW_LIMIT) begin
      row = (phase == 1) ? fixed_tab[k % 16] : rand_tab[k % RAND_ROWS];
      op  = OP_NONE;
      // Stray accesses at fixed rows of each phase
      if (phase == 1 && k == 0) begin
        op = OP_STATUS;
      end else if (phase == 2) begin
        case (k)
          1: op = OP_STATUS;
          2: op = OP_WR_STATUS;
          4: op = OP_WR_ENTROPY;
          6: op = OP_UNUSED;
          default: op = OP_NONE;
        endcase
      end
      run_slot(row, op, rd);
      k++;
    end
    if (!m_valid) begin
      $display("Timeout: model did not collect 32 bits in %0d rows", ROW_LIMIT);
      errors++;
      end_run();
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    clk           = 1'b0;
    cycle_ctr_rst = 1'b1;
    osc_f         = '0;
    osc_g         = '0;
    cs            = 1'b0;
    we            = 1'b0;
    address       = '0;
    write_data    = '0;
    errors        = 0;
    checks        = 0;
    strobe_idx    = -1;
    m_word        = '0;
    m_count       = 0;
    m_valid       = 1'b0;
    first_pf      = 1'b0;
    first_pg      = 1'b0;
    idle_row      = '0;
    pend_row      = '0;
    rnd_f         = '0;
    rnd_g         = '0;

    // Pair results 0, 1, reject, 0
    fixed_tab[0]  = make_row(4'h1, 4'h0, 0, 0, 0);
    fixed_tab[1]  = make_row(4'h0, 4'h0, 1, 1, 0);
    fixed_tab[2]  = make_row(4'h0, 4'h0, 0, 0, 0);
    fixed_tab[3]  = make_row(4'h0, 4'h1, 1, 1, 1);
    fixed_tab[4]  = make_row(4'h3, 4'h3, 0, 0, 0);
    fixed_tab[5]  = make_row(4'h3, 4'h3, 1, 0, 0);
    fixed_tab[6]  = make_row(4'h7, 4'h1, 0, 0, 0);
    fixed_tab[7]  = make_row(4'h6, 4'h1, 1, 1, 0);
    // Pair results reject, 1, 0, 1
    fixed_tab[8]  = make_row(4'hf, 4'h2, 0, 0, 0);
    fixed_tab[9]  = make_row(4'hf, 4'h4, 1, 0, 0);
    fixed_tab[10] = make_row(4'h8, 4'he, 0, 0, 0);
    fixed_tab[11] = make_row(4'h8, 4'h3, 1, 1, 1);
    fixed_tab[12] = make_row(4'h5, 4'ha, 0, 0, 0);
    fixed_tab[13] = make_row(4'h4, 4'ha, 1, 1, 0);
    fixed_tab[14] = make_row(4'hc, 4'h1, 0, 0, 0);
    fixed_tab[15] = make_row(4'hc, 4'h9, 1, 1, 1);

    void'($urandom(32'ha832));
    for (n = 0; n < RAND_ROWS; n++) begin
      rnd_f       = $urandom;
      rnd_g       = $urandom;
      rand_tab[n] = make_row(rnd_f[NUM_ROSC-1:0], rnd_g[NUM_ROSC-1:0], 0, 0, 0);
    end

    repeat (4) @(posedge clk);
    cycle_ctr_rst <= 1'b0;

    // Reset values through the bus
    run_slot(idle_row, OP_STATUS, rdata);
    run_slot(idle_row, OP_ENTROPY, rdata);

    // First word from the fixed table
    align_to_pair();
    feed_rows(1, 0);
    poll_ready();

    // Accepting rows must not touch a waiting word
    for (n = 0; n < 16; n++) begin
      run_slot(fixed_tab[n], (n % 2 == 1) ? OP_STATUS : OP_NONE, rdata);
    end

    // Read the first word and run random rows with stray accesses
    align_to_pair();
    run_slot(rand_tab[0], OP_ENTROPY, rdata);
    feed_rows(2, 1);
    poll_ready();
    run_slot(idle_row, OP_ENTROPY, rdata);
    run_slot(idle_row, OP_STATUS, rdata);

    end_run();
  end

endmodule

`default_nettype wire
